/* fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit
(
	input  logic clk,
	input  logic rst,
	input  logic redirect,
	input  lc3b_isa_pkg::lc3b_word redirect_pc,
	input  logic queue_full,
	output lc3b_isa_pkg::lc3b_word imem_addr,
	input  lc3b_isa_pkg::lc3b_word imem_rdata,
	output logic push,
	output lc3b_isa_pkg::lc3b_word push_instr,
	output lc3b_isa_pkg::lc3b_word push_pc
);

	lc3b_isa_pkg::lc3b_word pc;
	lc3b_isa_pkg::lc3b_word pc_next;

	assign pc_next = pc + 16'd2;
	assign imem_addr = pc;

	// Fetch stream after a taken redirect is stale, hold it back
	assign push = !queue_full && !redirect;
	assign push_instr = imem_rdata;
	assign push_pc = pc_next;       // LC-3b PC-relative base

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (redirect)
			pc <= redirect_pc;  // Queue flushes on the same edge
		else if (push)
			pc <= pc_next;
	end

endmodule

/* filelist.f */
lc3b_isa_pkg.sv
tomasulo_pkg.sv
fetch_unit.sv
instr_queue.sv
reg_status.sv
issue_control.sv
issue_stage.sv
tb_clock.sv
tb_issue_stage.sv

/* instr_queue.sv */
`timescale 1ns/1ns

module instr_queue
(
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic push,
	input  lc3b_isa_pkg::lc3b_word push_instr,
	input  lc3b_isa_pkg::lc3b_word push_pc,
	input  logic pop,
	output logic full,
	output logic instr_valid,
	output lc3b_isa_pkg::lc3b_word head_instr,
	output lc3b_isa_pkg::lc3b_word head_pc
);

	lc3b_isa_pkg::lc3b_word instr_mem [tomasulo_pkg::queue_depth];
	lc3b_isa_pkg::lc3b_word pc_mem [tomasulo_pkg::queue_depth];
	logic [tomasulo_pkg::queue_ptr_width-1:0] rd_ptr;
	logic [tomasulo_pkg::queue_ptr_width-1:0] wr_ptr;
	logic [tomasulo_pkg::queue_ptr_width:0] count;   // One extra bit for full

	assign full = (count == (tomasulo_pkg::queue_ptr_width+1)'(tomasulo_pkg::queue_depth));
	assign instr_valid = (count != '0);

	// Head is read straight out of the storage flops
	assign head_instr = instr_mem[rd_ptr];
	assign head_pc = pc_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			instr_mem[wr_ptr] <= push_instr;
			pc_mem[wr_ptr] <= push_pc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;                  // Both or neither, no change
			endcase
		end
	end

	// Fetch and issue must respect the queue flags
	assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("push into full instruction queue");
	assert property (@(posedge clk) disable iff (rst) pop |-> instr_valid)
		else $error("pop from empty instruction queue");

endmodule

/* issue_control.sv */
`timescale 1ns/1ns

module issue_control
(
	input  logic instr_valid,
	input  lc3b_isa_pkg::lc3b_word instr, curr_pc,
	output logic pop,
	output logic redirect,
	output lc3b_isa_pkg::lc3b_word redirect_pc,
	// Register status table
	output lc3b_isa_pkg::lc3b_reg sr1, sr2, src_dst,
	input  lc3b_isa_pkg::lc3b_word sr1_value, sr2_value, src_dst_value,
	input  logic sr1_busy, sr2_busy, src_dst_busy,
	input  tomasulo_pkg::rob_tag sr1_tag, sr2_tag, src_dst_tag,
	output logic rename_en,
	output lc3b_isa_pkg::lc3b_reg rename_reg,
	output tomasulo_pkg::rob_tag rename_tag,
	// ROB
	input  logic rob_full,
	input  tomasulo_pkg::rob_tag rob_addr,
	output tomasulo_pkg::rob_tag rob_sr1_read_addr, rob_sr2_read_addr,
	input  lc3b_isa_pkg::lc3b_word rob_sr1_value, rob_sr2_value,
	input  logic rob_sr1_valid, rob_sr2_valid,
	output logic rob_write_enable,
	output lc3b_isa_pkg::lc3b_reg rob_dest,
	output lc3b_isa_pkg::lc3b_word rob_value,
	// CDB
	input  logic cdb_valid,
	input  tomasulo_pkg::rob_tag cdb_tag,
	input  lc3b_isa_pkg::lc3b_word cdb_data,
	// Station and buffer status, predictor
	input  logic [tomasulo_pkg::alu_station_count-1:0] alu_busy,
	input  logic ldstr_full,
	input  logic predict_bit,
	// ALU reservation stations
	output logic res_write_enable,
	output tomasulo_pkg::station_id res_station_id,
	output lc3b_isa_pkg::lc3b_opcode res_op,
	output lc3b_isa_pkg::lc3b_word res_vj, res_vk,
	output tomasulo_pkg::rob_tag res_qj, res_qk,
	output logic res_vj_valid, res_vk_valid,
	// Load/store buffer
	output logic ldstr_write_enable, ldstr_store,
	output lc3b_isa_pkg::lc3b_word ldstr_offset, ldstr_vbase, ldstr_vsrc,
	output logic ldstr_vbase_valid, ldstr_vsrc_valid,
	output tomasulo_pkg::rob_tag ldstr_qbase, ldstr_qsrc, ldstr_dest
);

	lc3b_isa_pkg::lc3b_opcode opcode;
	lc3b_isa_pkg::lc3b_word imm5, off6, pc_rel9, jsr_target;
	logic is_alu, is_mem, is_str, jsrr, use_imm, stall, go;
	logic a_ready, b_ready, b_busy;
	lc3b_isa_pkg::lc3b_word a_value, b_value, b_reg_value;
	tomasulo_pkg::rob_tag b_tag;

	// Returns {ready, value} by register, CDB, ROB priority
	function automatic logic [$bits(lc3b_isa_pkg::lc3b_word):0] resolve(
		input logic busy,
		input lc3b_isa_pkg::lc3b_word reg_val,
		input tomasulo_pkg::rob_tag tag,
		input logic rob_valid,
		input lc3b_isa_pkg::lc3b_word rob_val);
		if (!busy)
			return {1'b1, reg_val};
		if (cdb_valid && cdb_tag == tag)
			return {1'b1, cdb_data};    // Result on the bus this cycle
		if (rob_valid)
			return {1'b1, rob_val};     // Done but not committed
		return {1'b0, 16'h0000};
	endfunction

	assign opcode = lc3b_isa_pkg::lc3b_opcode'(instr[15:12]);
	assign sr1 = instr[8:6];
	assign sr2 = instr[2:0];
	assign src_dst = instr[11:9];     // Destination, or store source

	assign is_alu = opcode inside {lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and,
		lc3b_isa_pkg::op_not};
	assign is_mem = opcode inside {lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_str};
	assign is_str = (opcode == lc3b_isa_pkg::op_str);
	assign jsrr = (opcode == lc3b_isa_pkg::op_jsr) && !instr[11];
	assign use_imm = (opcode == lc3b_isa_pkg::op_not) || instr[5];

	assign imm5 = lc3b_isa_pkg::lc3b_word'($signed(instr[lc3b_isa_pkg::imm5_width-1:0]));
	assign off6 = lc3b_isa_pkg::lc3b_word'($signed(instr[lc3b_isa_pkg::offset6_width-1:0])) << 1;
	assign pc_rel9 = curr_pc
		+ (lc3b_isa_pkg::lc3b_word'($signed(instr[lc3b_isa_pkg::offset9_width-1:0])) << 1);
	assign jsr_target = instr[11] ? curr_pc
		+ (lc3b_isa_pkg::lc3b_word'($signed(instr[lc3b_isa_pkg::offset11_width-1:0])) << 1)
		: a_value;

	// Second ROB lookup serves the store data register on STR
	assign b_busy = is_str ? src_dst_busy : sr2_busy;
	assign b_reg_value = is_str ? src_dst_value : sr2_value;
	assign b_tag = is_str ? src_dst_tag : sr2_tag;
	assign rob_sr1_read_addr = sr1_tag;
	assign rob_sr2_read_addr = b_tag;

	always_comb
	begin
		{a_ready, a_value} = resolve(sr1_busy, sr1_value, sr1_tag, rob_sr1_valid, rob_sr1_value);
		{b_ready, b_value} = resolve(b_busy, b_reg_value, b_tag, rob_sr2_valid, rob_sr2_value);
	end

	assign stall = rob_full
		|| (is_alu && (&alu_busy))
		|| (is_mem && ldstr_full)
		|| (jsrr && !a_ready);        // Target unknown, hold the head
	assign go = instr_valid && !stall;
	assign pop = go;

	// Lowest numbered free station
	always_comb
	begin
		res_station_id = '0;
		for (int i = tomasulo_pkg::alu_station_count - 1; i >= 0; i--)
		begin
			if (!alu_busy[i])
				res_station_id = tomasulo_pkg::station_id'(i);
		end
	end

	// Payloads, qualified by the write strobes
	assign res_op = opcode;
	assign res_vj = a_value;
	assign res_vj_valid = a_ready;
	assign res_qj = a_ready ? '0 : sr1_tag;
	assign res_vk = use_imm ? imm5 : b_value;
	assign res_vk_valid = use_imm || b_ready;
	assign res_qk = res_vk_valid ? '0 : b_tag;
	assign ldstr_store = is_str;
	assign ldstr_offset = off6;
	assign ldstr_vbase = a_value;
	assign ldstr_vbase_valid = a_ready;
	assign ldstr_qbase = a_ready ? '0 : sr1_tag;
	assign ldstr_vsrc = b_value;
	assign ldstr_vsrc_valid = b_ready || !is_str;
	assign ldstr_qsrc = ldstr_vsrc_valid ? '0 : b_tag;
	assign ldstr_dest = rob_addr;
	assign rename_tag = rob_addr;
	assign redirect_pc = (opcode == lc3b_isa_pkg::op_jsr) ? jsr_target : pc_rel9;

	always_comb
	begin
		res_write_enable = 1'b0;
		ldstr_write_enable = 1'b0;
		rob_write_enable = 1'b0;
		rob_dest = src_dst;
		rob_value = '0;
		rename_en = 1'b0;
		rename_reg = src_dst;
		redirect = 1'b0;
		if (go)
		begin
			case (opcode)
				lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not:
				begin
					res_write_enable = 1'b1;
					rob_write_enable = 1'b1;
					rename_en = 1'b1;
				end
				lc3b_isa_pkg::op_ldr:
				begin
					ldstr_write_enable = 1'b1;
					rob_write_enable = 1'b1;
					rename_en = 1'b1;
				end
				lc3b_isa_pkg::op_str:
				begin
					ldstr_write_enable = 1'b1;
					rob_write_enable = 1'b1;
					rob_dest = '0;          // No register result
				end
				lc3b_isa_pkg::op_br:
				begin
					rob_write_enable = 1'b1;    // rob_dest carries nzp
					if (predict_bit)
					begin
						rob_value = curr_pc;    // Recovery PC if mispredicted
						redirect = 1'b1;
					end
					else
						rob_value = pc_rel9;
				end
				lc3b_isa_pkg::op_lea:
				begin
					rob_write_enable = 1'b1;
					rob_value = pc_rel9;
					rename_en = 1'b1;
				end
				lc3b_isa_pkg::op_jsr:
				begin
					rob_write_enable = 1'b1;
					rob_value = curr_pc;        // Return address
					rob_dest = lc3b_isa_pkg::link_reg;
					rename_en = 1'b1;
					rename_reg = lc3b_isa_pkg::link_reg;
					redirect = 1'b1;
				end
				default: ;                      // Unsupported, dropped at issue
			endcase
		end
	end

endmodule

/* issue_stage.sv */
`timescale 1ns/1ns

module issue_stage
(
	input  logic clk, rst,
	output lc3b_isa_pkg::lc3b_word imem_addr,
	input  lc3b_isa_pkg::lc3b_word imem_rdata,
	input  logic cdb_valid,
	input  tomasulo_pkg::rob_tag cdb_tag,
	input  lc3b_isa_pkg::lc3b_word cdb_data,
	input  logic rob_full,
	input  tomasulo_pkg::rob_tag rob_addr,
	output tomasulo_pkg::rob_tag rob_sr1_read_addr, rob_sr2_read_addr,
	input  lc3b_isa_pkg::lc3b_word rob_sr1_value, rob_sr2_value,
	input  logic rob_sr1_valid, rob_sr2_valid,
	input  logic [tomasulo_pkg::alu_station_count-1:0] alu_busy,
	input  logic ldstr_full,
	input  logic predict_bit,
	output logic pop, redirect,
	output lc3b_isa_pkg::lc3b_word redirect_pc,
	output logic rob_write_enable,
	output lc3b_isa_pkg::lc3b_reg rob_dest,
	output lc3b_isa_pkg::lc3b_word rob_value,
	output logic res_write_enable,
	output tomasulo_pkg::station_id res_station_id,
	output lc3b_isa_pkg::lc3b_opcode res_op,
	output lc3b_isa_pkg::lc3b_word res_vj, res_vk,
	output tomasulo_pkg::rob_tag res_qj, res_qk,
	output logic res_vj_valid, res_vk_valid,
	output logic ldstr_write_enable, ldstr_store,
	output lc3b_isa_pkg::lc3b_word ldstr_offset, ldstr_vbase, ldstr_vsrc,
	output logic ldstr_vbase_valid, ldstr_vsrc_valid,
	output tomasulo_pkg::rob_tag ldstr_qbase, ldstr_qsrc, ldstr_dest
);

	// Fetch to queue
	logic push, queue_full;
	lc3b_isa_pkg::lc3b_word push_instr, push_pc;
	// Queue head
	logic instr_valid;
	lc3b_isa_pkg::lc3b_word head_instr, head_pc;
	// Register status lookups and rename
	lc3b_isa_pkg::lc3b_reg sr1, sr2, src_dst, rename_reg;
	lc3b_isa_pkg::lc3b_word sr1_value, sr2_value, src_dst_value;
	logic sr1_busy, sr2_busy, src_dst_busy, rename_en;
	tomasulo_pkg::rob_tag sr1_tag, sr2_tag, src_dst_tag, rename_tag;

	fetch_unit fetch
	(
		.clk, .rst, .redirect, .redirect_pc, .queue_full,
		.imem_addr, .imem_rdata, .push, .push_instr, .push_pc
	);

	instr_queue queue
	(
		.clk, .rst, .flush(redirect), .push, .push_instr, .push_pc, .pop,
		.full(queue_full), .instr_valid, .head_instr, .head_pc
	);

	reg_status regs
	(
		.clk, .rst, .sr1, .sr2, .src_dst,
		.sr1_value, .sr2_value, .src_dst_value,
		.sr1_busy, .sr2_busy, .src_dst_busy,
		.sr1_tag, .sr2_tag, .src_dst_tag,
		.rename_en, .rename_reg, .rename_tag,
		.cdb_valid, .cdb_tag, .cdb_data
	);

	issue_control issue
	(
		.instr_valid, .instr(head_instr), .curr_pc(head_pc),
		.pop, .redirect, .redirect_pc,
		.sr1, .sr2, .src_dst, .sr1_value, .sr2_value, .src_dst_value,
		.sr1_busy, .sr2_busy, .src_dst_busy, .sr1_tag, .sr2_tag, .src_dst_tag,
		.rename_en, .rename_reg, .rename_tag,
		.rob_full, .rob_addr, .rob_sr1_read_addr, .rob_sr2_read_addr,
		.rob_sr1_value, .rob_sr2_value, .rob_sr1_valid, .rob_sr2_valid,
		.rob_write_enable, .rob_dest, .rob_value,
		.cdb_valid, .cdb_tag, .cdb_data,
		.alu_busy, .ldstr_full, .predict_bit,
		.res_write_enable, .res_station_id, .res_op, .res_vj, .res_vk,
		.res_qj, .res_qk, .res_vj_valid, .res_vk_valid,
		.ldstr_write_enable, .ldstr_store, .ldstr_offset, .ldstr_vbase,
		.ldstr_vbase_valid, .ldstr_qbase, .ldstr_vsrc, .ldstr_vsrc_valid,
		.ldstr_qsrc, .ldstr_dest
	);

endmodule

/* lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	localparam int reg_count = 8;
	localparam lc3b_reg link_reg = 3'd7;     // JSR/JSRR return address

	// Immediate and offset field widths
	localparam int imm5_width = 5;
	localparam int offset6_width = 6;
	localparam int offset9_width = 9;
	localparam int offset11_width = 11;

	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,   // JSR and JSRR
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage

/* reg_status.sv */
`timescale 1ns/1ns

module reg_status
(
	input  logic clk,
	input  logic rst,
	input  lc3b_isa_pkg::lc3b_reg sr1,
	input  lc3b_isa_pkg::lc3b_reg sr2,
	input  lc3b_isa_pkg::lc3b_reg src_dst,
	output lc3b_isa_pkg::lc3b_word sr1_value,
	output lc3b_isa_pkg::lc3b_word sr2_value,
	output lc3b_isa_pkg::lc3b_word src_dst_value,
	output logic sr1_busy,
	output logic sr2_busy,
	output logic src_dst_busy,
	output tomasulo_pkg::rob_tag sr1_tag,
	output tomasulo_pkg::rob_tag sr2_tag,
	output tomasulo_pkg::rob_tag src_dst_tag,
	input  logic rename_en,
	input  lc3b_isa_pkg::lc3b_reg rename_reg,
	input  tomasulo_pkg::rob_tag rename_tag,
	input  logic cdb_valid,
	input  tomasulo_pkg::rob_tag cdb_tag,
	input  lc3b_isa_pkg::lc3b_word cdb_data
);

	lc3b_isa_pkg::lc3b_word value [lc3b_isa_pkg::reg_count];
	logic [lc3b_isa_pkg::reg_count-1:0] busy;
	tomasulo_pkg::rob_tag tag [lc3b_isa_pkg::reg_count];

	// Three combinational read ports
	assign sr1_value = value[sr1];
	assign sr1_busy = busy[sr1];
	assign sr1_tag = tag[sr1];
	assign sr2_value = value[sr2];
	assign sr2_busy = busy[sr2];
	assign sr2_tag = tag[sr2];
	assign src_dst_value = value[src_dst];
	assign src_dst_busy = busy[src_dst];
	assign src_dst_tag = tag[src_dst];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < lc3b_isa_pkg::reg_count; i++)
			begin
				value[i] <= '0;
				busy[i] <= 1'b0;
				tag[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < lc3b_isa_pkg::reg_count; i++)
			begin
				if (rename_en && rename_reg == lc3b_isa_pkg::lc3b_reg'(i))
				begin
					busy[i] <= 1'b1;        // New producer takes over
					tag[i] <= rename_tag;
				end
				else if (cdb_valid && busy[i] && tag[i] == cdb_tag)
				begin
					value[i] <= cdb_data;
					busy[i] <= 1'b0;
				end
			end
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_stage \
	-f filelist.f -o sim_issue_stage

status=0
./obj_dir/sim_issue_stage > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Simulation ended without a verdict, exit status $status"
	exit 1
fi
exit 0

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;  // 8 ns period
	end

endmodule

/* tb_issue_stage.sv */
`timescale 1ns/1ns

module tb_issue_stage;

	localparam int issue_target = 400;
	localparam int cycle_limit = 4000;
	localparam logic [31:0] start_seed = 32'h0bd3_15e6;

	logic clk, rst;
	lc3b_isa_pkg::lc3b_word imem_addr, imem_rdata;
	logic cdb_valid;
	tomasulo_pkg::rob_tag cdb_tag;
	lc3b_isa_pkg::lc3b_word cdb_data;
	logic rob_full;
	tomasulo_pkg::rob_tag rob_addr, rob_sr1_read_addr, rob_sr2_read_addr;
	lc3b_isa_pkg::lc3b_word rob_sr1_value, rob_sr2_value;
	logic rob_sr1_valid, rob_sr2_valid;
	logic [tomasulo_pkg::alu_station_count-1:0] alu_busy;
	logic ldstr_full, predict_bit;
	logic pop, redirect;
	lc3b_isa_pkg::lc3b_word redirect_pc;
	logic rob_write_enable;
	lc3b_isa_pkg::lc3b_reg rob_dest;
	lc3b_isa_pkg::lc3b_word rob_value;
	logic res_write_enable;
	tomasulo_pkg::station_id res_station_id;
	lc3b_isa_pkg::lc3b_opcode res_op;
	lc3b_isa_pkg::lc3b_word res_vj, res_vk;
	tomasulo_pkg::rob_tag res_qj, res_qk;
	logic res_vj_valid, res_vk_valid;
	logic ldstr_write_enable, ldstr_store;
	lc3b_isa_pkg::lc3b_word ldstr_offset, ldstr_vbase, ldstr_vsrc;
	logic ldstr_vbase_valid, ldstr_vsrc_valid;
	tomasulo_pkg::rob_tag ldstr_qbase, ldstr_qsrc, ldstr_dest;

	// Reference model state
	lc3b_isa_pkg::lc3b_word prog [64];
	lc3b_isa_pkg::lc3b_word model_pc;
	lc3b_isa_pkg::lc3b_word fifo_instr [$];
	lc3b_isa_pkg::lc3b_word fifo_pc [$];
	lc3b_isa_pkg::lc3b_word reg_val [8];
	logic reg_busy [8];
	tomasulo_pkg::rob_tag reg_tag [8];
	int errors, checks, issued, cycles;

	tb_clock clock_gen (.clk);

	issue_stage UUT (.*);

	function automatic lc3b_isa_pkg::lc3b_word sign_extend(input lc3b_isa_pkg::lc3b_word field,
		input int width);
		lc3b_isa_pkg::lc3b_word result;
		result = field;
		for (int i = width; i < 16; i++)
			result[i] = field[width-1];
		return result;
	endfunction

	// Only the supported opcodes, remaining fields random
	function automatic lc3b_isa_pkg::lc3b_word random_instr();
		logic [31:0] rnd;
		lc3b_isa_pkg::lc3b_opcode op;
		rnd = $urandom;
		case (rnd[14:12])
			3'd0: op = lc3b_isa_pkg::op_add;
			3'd1: op = lc3b_isa_pkg::op_and;
			3'd2: op = lc3b_isa_pkg::op_not;
			3'd3: op = lc3b_isa_pkg::op_ldr;
			3'd4: op = lc3b_isa_pkg::op_str;
			3'd5: op = lc3b_isa_pkg::op_br;
			3'd6: op = lc3b_isa_pkg::op_lea;
			default: op = lc3b_isa_pkg::op_jsr;
		endcase
		return {op, rnd[11:0]};
	endfunction

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	// Register value, then CDB, then ROB, else wait on the tag
	task automatic resolve_operand(input lc3b_isa_pkg::lc3b_reg r, input logic rob_valid,
		input lc3b_isa_pkg::lc3b_word rob_val, output logic ready,
		output lc3b_isa_pkg::lc3b_word value, output tomasulo_pkg::rob_tag tag);
		tag = reg_tag[r];
		ready = 1'b1;
		if (!reg_busy[r])
			value = reg_val[r];
		else if (cdb_valid && cdb_tag == reg_tag[r])
			value = cdb_data;
		else if (rob_valid)
			value = rob_val;
		else
		begin
			ready = 1'b0;
			value = '0;
		end
	endtask

	task automatic drive_environment();
		logic [31:0] rnd;
		logic [31:0] data;
		logic [31:0] extra;
		rnd = $urandom;
		data = $urandom;
		extra = $urandom;
		rob_full = (rnd[2:0] == 3'd0);
		alu_busy = rnd[5:3];
		ldstr_full = (rnd[7:6] == 2'd0);
		predict_bit = (rnd[9:8] == 2'd0);
		cdb_valid = rnd[10];
		cdb_tag = rnd[13:11];
		rob_sr1_valid = (rnd[15:14] == 2'd0);
		rob_sr2_valid = (rnd[17:16] == 2'd0);
		rob_addr = rnd[20:18];
		cdb_data = data[15:0];
		rob_sr1_value = data[31:16];
		rob_sr2_value = extra[15:0];
		imem_rdata = prog[imem_addr[6:1]];     // Word addressed, wraps in 64 words
	endtask

	task automatic check_cycle();
		lc3b_isa_pkg::lc3b_word instr, pc, target, a_value, b_value;
		lc3b_isa_pkg::lc3b_opcode op;
		lc3b_isa_pkg::lc3b_reg dst;
		tomasulo_pkg::rob_tag a_tag, b_tag;
		logic valid, alu, mem, store, jsrr, renames, stall, go, jump, push;
		logic a_ready, b_ready;
		int station;
		valid = (fifo_instr.size() != 0);
		instr = '0;
		pc = '0;
		if (valid)
		begin
			instr = fifo_instr[0];
			pc = fifo_pc[0];
		end
		op = lc3b_isa_pkg::lc3b_opcode'(instr[15:12]);
		dst = (op == lc3b_isa_pkg::op_jsr) ? lc3b_isa_pkg::link_reg : instr[11:9];
		alu = op inside {lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not};
		mem = op inside {lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_str};
		store = (op == lc3b_isa_pkg::op_str);
		jsrr = (op == lc3b_isa_pkg::op_jsr) && !instr[11];
		renames = alu || op inside {lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_lea,
			lc3b_isa_pkg::op_jsr};
		resolve_operand(instr[8:6], rob_sr1_valid, rob_sr1_value, a_ready, a_value, a_tag);
		resolve_operand(store ? instr[11:9] : instr[2:0], rob_sr2_valid, rob_sr2_value,
			b_ready, b_value, b_tag);
		stall = rob_full || (alu && alu_busy == 3'b111) || (mem && ldstr_full)
			|| (jsrr && !a_ready);
		go = valid && !stall;
		jump = go && ((op == lc3b_isa_pkg::op_br && predict_bit) || op == lc3b_isa_pkg::op_jsr);
		if (op == lc3b_isa_pkg::op_jsr)
			target = instr[11] ? pc + (sign_extend(instr, 11) << 1) : a_value;
		else
			target = pc + (sign_extend(instr, 9) << 1);

		compare("imem_addr", imem_addr, model_pc);
		compare("pop", pop, go);
		compare("redirect", redirect, jump);
		compare("rob_write_enable", rob_write_enable, go);
		compare("res_write_enable", res_write_enable, go && alu);
		compare("ldstr_write_enable", ldstr_write_enable, go && mem);
		if (valid)
		begin
			compare("rob_sr1_read_addr", rob_sr1_read_addr, a_tag);    // ROB looked up by tag
			compare("rob_sr2_read_addr", rob_sr2_read_addr, b_tag);
		end
		if (jump)
			compare("redirect_pc", redirect_pc, target);
		if (go && alu)
		begin
			station = 0;
			while (alu_busy[station])
				station++;                      // A free one exists, no stall
			compare("res_station_id", res_station_id, tomasulo_pkg::station_id'(station));
			compare("res_op", res_op, op);
			compare("res_vj_valid", res_vj_valid, a_ready);
			if (a_ready)
				compare("res_vj", res_vj, a_value);
			else
				compare("res_qj", res_qj, a_tag);
			if (op == lc3b_isa_pkg::op_not || instr[5])
			begin
				compare("res_vk_valid", res_vk_valid, 1'b1);
				compare("res_vk", res_vk, sign_extend(instr, 5));
			end
			else
			begin
				compare("res_vk_valid", res_vk_valid, b_ready);
				if (b_ready)
					compare("res_vk", res_vk, b_value);
				else
					compare("res_qk", res_qk, b_tag);
			end
		end
		if (go && mem)
		begin
			compare("ldstr_store", ldstr_store, store);
			compare("ldstr_offset", ldstr_offset, sign_extend(instr, 6) << 1);
			compare("ldstr_dest", ldstr_dest, rob_addr);
			compare("ldstr_vbase_valid", ldstr_vbase_valid, a_ready);
			if (a_ready)
				compare("ldstr_vbase", ldstr_vbase, a_value);
			else
				compare("ldstr_qbase", ldstr_qbase, a_tag);
			if (store)
			begin
				compare("ldstr_vsrc_valid", ldstr_vsrc_valid, b_ready);
				if (b_ready)
					compare("ldstr_vsrc", ldstr_vsrc, b_value);
				else
					compare("ldstr_qsrc", ldstr_qsrc, b_tag);
			end
		end
		if (go && renames)
			compare("rob_dest", rob_dest, dst);
		if (go && op == lc3b_isa_pkg::op_lea)
			compare("rob_value", rob_value, target);
		if (go && op == lc3b_isa_pkg::op_jsr)
			compare("rob_value", rob_value, pc);   // Return address
		if (go && op == lc3b_isa_pkg::op_br)
			compare("rob_value", rob_value, predict_bit ? pc : target);

		// Rename beats a CDB match on the same register
		for (int r = 0; r < 8; r++)
		begin
			if (go && renames && int'(dst) == r)
			begin
				reg_busy[r] = 1'b1;
				reg_tag[r] = rob_addr;
			end
			else if (cdb_valid && reg_busy[r] && reg_tag[r] == cdb_tag)
			begin
				reg_val[r] = cdb_data;
				reg_busy[r] = 1'b0;
			end
		end

		push = (fifo_instr.size() < tomasulo_pkg::queue_depth) && !jump;
		if (jump)
		begin
			fifo_instr.delete();                // Flush, new fetch from target
			fifo_pc.delete();
			model_pc = target;
		end
		if (go && !jump)
		begin
			void'(fifo_instr.pop_front());
			void'(fifo_pc.pop_front());
		end
		if (push)
		begin
			fifo_instr.push_back(prog[model_pc[6:1]]);
			fifo_pc.push_back(model_pc + 16'd2);
			model_pc = model_pc + 16'd2;
		end
		if (go)
			issued++;
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		issued = 0;
		cycles = 0;
		void'($urandom(start_seed));
		for (int i = 0; i < 64; i++)
			prog[i] = random_instr();
		rst = 1'b1;
		imem_rdata = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		rob_full = 1'b0;
		rob_addr = '0;
		rob_sr1_value = '0;
		rob_sr2_value = '0;
		rob_sr1_valid = 1'b0;
		rob_sr2_valid = 1'b0;
		alu_busy = '0;
		ldstr_full = 1'b0;
		predict_bit = 1'b0;
		model_pc = '0;
		for (int r = 0; r < 8; r++)
		begin
			reg_val[r] = '0;
			reg_busy[r] = 1'b0;
			reg_tag[r] = '0;
		end
		repeat (10) @(posedge clk);

		// Drive on the falling edge, check halfway to the rising edge
		while (issued < issue_target && cycles < cycle_limit)
		begin
			@(negedge clk);
			rst = 1'b0;
			drive_environment();
			#2;
			check_cycle();
			cycles++;
		end
		if (issued < issue_target)
		begin
			errors++;
			$display("Timeout: only %0d of %0d instructions issued in %0d cycles",
				issued, issue_target, cycles);
		end

		$display("Issued %0d instructions in %0d cycles, %0d checks, %0d errors",
			issued, cycles, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* tomasulo_pkg.sv */
package tomasulo_pkg;

	// ROB entries are addressed by tag
	localparam int tag_width = 3;
	typedef logic [tag_width-1:0] rob_tag;

	// ALU reservation stations
	localparam int alu_station_count = 3;
	typedef logic [$clog2(alu_station_count)-1:0] station_id;

	// Instruction queue, depth kept a power of two
	localparam int queue_depth = 4;
	localparam int queue_ptr_width = $clog2(queue_depth);

endpackage
